// ==== Makefile ====
# Verilator flow for the safety island memory fabric

TOP = tb_island

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
design/island_pkg.sv
design/mem_bus_if.sv
design/sram_bank.sv
design/soc_ctrl_regs.sv
design/periph_subsystem.sv
design/island_xbar.sv
design/island_top.sv
sim/tb_island.sv

// ==== design/island_pkg.sv ====
// Island package with bus widths, address map, boot mode encoding and boot ROM image
`default_nettype none

package island_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  typedef enum logic [1:0] {
    BootJtag      = 2'd0,
    BootPreloaded = 2'd1,
    BootRom       = 2'd2
  } boot_mode_e;

  // --------------------
  // Address map
  // --------------------
  localparam int unsigned BankNumBytes = 1024;
  localparam addr_t BankOffset   = 32'h0000_0000;
  localparam addr_t PeriphOffset = 32'h0020_0000;
  localparam addr_t IslandEnd    = 32'h0080_0000;

  // Relative to PeriphOffset
  localparam addr_t SocCtrlOffset = 32'h0000_0000;
  localparam addr_t SocCtrlRange  = 32'h0000_1000;
  localparam addr_t BootRomOffset = 32'h0000_1000;
  localparam addr_t BootRomRange  = 32'h0000_1000;

  localparam addr_t RegBootAddr = 32'h0;
  localparam addr_t RegFetchEn  = 32'h4;
  localparam addr_t RegBootMode = 32'h8;

  localparam data_t ErrorPattern = 32'hBADCAB1E;

  // --------------------
  // Boot ROM
  // --------------------
  localparam int unsigned BootRomWords = 16;

  // Small boot stub, parks in a wfi loop
  localparam data_t boot_rom_table [BootRomWords] = '{
    32'h0020_02b7, 32'h0002_a303, 32'h0043_0313, 32'h0062_a023,
    32'h0000_0013, 32'h0000_0013, 32'h1050_0073, 32'hffdf_f06f,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_006f
  };

  localparam addr_t BootAddrDefault = PeriphOffset + BootRomOffset + 32'h80;

endpackage

`default_nettype wire

// ==== design/island_top.sv ====
// Safety island memory fabric top with two managers, two SRAM banks and peripherals
`timescale 1ns/10ps
`default_nettype none

module island_top #(
  parameter int unsigned BankBytes = island_pkg::BankNumBytes
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Core data port
  input  logic                   m0_req_i,
  input  logic                   m0_we_i,
  input  island_pkg::strb_t      m0_be_i,
  input  island_pkg::addr_t      m0_addr_i,
  input  island_pkg::data_t      m0_wdata_i,
  output logic                   m0_gnt_o,
  output logic                   m0_rvalid_o,
  output logic                   m0_err_o,
  output island_pkg::data_t      m0_rdata_o,
  // System input port
  input  logic                   m1_req_i,
  input  logic                   m1_we_i,
  input  island_pkg::strb_t      m1_be_i,
  input  island_pkg::addr_t      m1_addr_i,
  input  island_pkg::data_t      m1_wdata_i,
  output logic                   m1_gnt_o,
  output logic                   m1_rvalid_o,
  output logic                   m1_err_o,
  output island_pkg::data_t      m1_rdata_o,
  input  island_pkg::boot_mode_e bootmode_i,
  output logic                   fetch_enable_o,
  output island_pkg::addr_t      boot_addr_o
);

  localparam int unsigned BankWords = BankBytes / 4;

  mem_bus_if m0_bus ();
  mem_bus_if m1_bus ();
  mem_bus_if bank0_bus ();
  mem_bus_if bank1_bus ();
  mem_bus_if periph_bus ();

  assign m0_bus.req   = m0_req_i;
  assign m0_bus.we    = m0_we_i;
  assign m0_bus.be    = m0_be_i;
  assign m0_bus.addr  = m0_addr_i;
  assign m0_bus.wdata = m0_wdata_i;
  assign m0_gnt_o     = m0_bus.gnt;
  assign m0_rvalid_o  = m0_bus.rvalid;
  assign m0_err_o     = m0_bus.err;
  assign m0_rdata_o   = m0_bus.rdata;

  assign m1_bus.req   = m1_req_i;
  assign m1_bus.we    = m1_we_i;
  assign m1_bus.be    = m1_be_i;
  assign m1_bus.addr  = m1_addr_i;
  assign m1_bus.wdata = m1_wdata_i;
  assign m1_gnt_o     = m1_bus.gnt;
  assign m1_rvalid_o  = m1_bus.rvalid;
  assign m1_err_o     = m1_bus.err;
  assign m1_rdata_o   = m1_bus.rdata;

  island_xbar #(
    .BankBytes ( BankBytes )
  ) u_xbar (
    .clk_i,
    .rst_ni,
    .m0_bus     ( m0_bus     ),
    .m1_bus     ( m1_bus     ),
    .bank0_bus  ( bank0_bus  ),
    .bank1_bus  ( bank1_bus  ),
    .periph_bus ( periph_bus )
  );

  // Instruction bank
  sram_bank #(
    .NumWords ( BankWords )
  ) u_bank0 (
    .clk_i,
    .rst_ni,
    .bus ( bank0_bus )
  );

  // Data bank
  sram_bank #(
    .NumWords ( BankWords )
  ) u_bank1 (
    .clk_i,
    .rst_ni,
    .bus ( bank1_bus )
  );

  periph_subsystem u_periph (
    .clk_i,
    .rst_ni,
    .bus            ( periph_bus ),
    .bootmode_i,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

`default_nettype wire

// ==== design/island_xbar.sv ====
// Two-manager crossbar to the memory banks and peripherals with round-robin arbitration
`timescale 1ns/10ps
`default_nettype none

module island_xbar #(
  parameter int unsigned BankBytes = island_pkg::BankNumBytes
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  mem_bus_if.subordinate m0_bus,
  mem_bus_if.subordinate m1_bus,
  mem_bus_if.manager     bank0_bus,
  mem_bus_if.manager     bank1_bus,
  mem_bus_if.manager     periph_bus
);

  localparam int unsigned NumTargets = 3;
  localparam int unsigned ReqW = 1 + island_pkg::StrbWidth + island_pkg::AddrWidth
                                 + island_pkg::DataWidth;
  localparam int unsigned RspW = island_pkg::DataWidth + 1;

  typedef logic [1:0] tgt_idx_t;

  localparam tgt_idx_t TgtBank0  = 2'd0;
  localparam tgt_idx_t TgtBank1  = 2'd1;
  localparam tgt_idx_t TgtPeriph = 2'd2;

  logic     [1:0]                 m_req, m_gnt, m_rvalid;
  logic     [1:0][ReqW-1:0]       m_wreq;
  logic     [1:0][RspW-1:0]       m_rsp;
  tgt_idx_t [1:0]                 m_tgt;
  logic     [NumTargets-1:0]      t_req, t_gnt, t_rvalid;
  logic     [NumTargets-1:0][ReqW-1:0] t_wreq;
  logic     [NumTargets-1:0][RspW-1:0] t_rsp;
  logic     [NumTargets-1:0][1:0] grant;

  // Request aggregate is {we, be, addr, wdata}
  assign m_req[0]  = m0_bus.req;
  assign m_wreq[0] = {m0_bus.we, m0_bus.be, m0_bus.addr, m0_bus.wdata};
  assign m0_bus.gnt    = m_gnt[0];
  assign m0_bus.rvalid = m_rvalid[0];
  assign {m0_bus.rdata, m0_bus.err} = m_rsp[0];

  assign m_req[1]  = m1_bus.req;
  assign m_wreq[1] = {m1_bus.we, m1_bus.be, m1_bus.addr, m1_bus.wdata};
  assign m1_bus.gnt    = m_gnt[1];
  assign m1_bus.rvalid = m_rvalid[1];
  assign {m1_bus.rdata, m1_bus.err} = m_rsp[1];

  assign bank0_bus.req = t_req[TgtBank0];
  assign {bank0_bus.we, bank0_bus.be, bank0_bus.addr, bank0_bus.wdata} = t_wreq[TgtBank0];
  assign t_gnt[TgtBank0]    = bank0_bus.gnt;
  assign t_rvalid[TgtBank0] = bank0_bus.rvalid;
  assign t_rsp[TgtBank0]    = {bank0_bus.rdata, bank0_bus.err};

  assign bank1_bus.req = t_req[TgtBank1];
  assign {bank1_bus.we, bank1_bus.be, bank1_bus.addr, bank1_bus.wdata} = t_wreq[TgtBank1];
  assign t_gnt[TgtBank1]    = bank1_bus.gnt;
  assign t_rvalid[TgtBank1] = bank1_bus.rvalid;
  assign t_rsp[TgtBank1]    = {bank1_bus.rdata, bank1_bus.err};

  assign periph_bus.req = t_req[TgtPeriph];
  assign {periph_bus.we, periph_bus.be, periph_bus.addr, periph_bus.wdata} = t_wreq[TgtPeriph];
  assign t_gnt[TgtPeriph]    = periph_bus.gnt;
  assign t_rvalid[TgtPeriph] = periph_bus.rvalid;
  assign t_rsp[TgtPeriph]    = {periph_bus.rdata, periph_bus.err};

  // --------------------
  // Arbitration
  // --------------------
  for (genvar t = 0; t < NumTargets; t++) begin : gen_arb
    logic [1:0] want;
    logic       prio_q;

    assign want[0] = m_req[0] && (m_tgt[0] == tgt_idx_t'(t));
    assign want[1] = m_req[1] && (m_tgt[1] == tgt_idx_t'(t));

    // prio_q set means m1 wins the next conflict
    assign grant[t][0] = want[0] && (!want[1] || !prio_q);
    assign grant[t][1] = want[1] && (!want[0] || prio_q);
    assign t_req[t]    = |want;
    assign t_wreq[t]   = grant[t][1] ? m_wreq[1] : m_wreq[0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        prio_q <= 1'b0;
      end else if (&want) begin
        prio_q <= grant[t][0];
      end
    end
  end

  // --------------------
  // Decode and response
  // --------------------
  for (genvar i = 0; i < 2; i++) begin : gen_mgr
    island_pkg::addr_t offset;
    logic              inflight_q;
    tgt_idx_t          route_q;

    assign offset = m_wreq[i][island_pkg::DataWidth +: island_pkg::AddrWidth]
                    - island_pkg::BankOffset;
    // Anything outside the banks goes to the peripheral target
    assign m_tgt[i] = (offset < BankBytes)     ? TgtBank0 :
                      (offset < 2 * BankBytes) ? TgtBank1 : TgtPeriph;

    assign m_gnt[i] = grant[m_tgt[i]][i] && t_gnt[m_tgt[i]];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        inflight_q <= 1'b0;
        route_q    <= TgtBank0;
      end else begin
        inflight_q <= m_req[i] && m_gnt[i];
        if (m_req[i] && m_gnt[i]) begin
          route_q <= m_tgt[i];
        end
      end
    end

    assign m_rvalid[i] = inflight_q && t_rvalid[route_q];
    assign m_rsp[i]    = t_rsp[route_q];
  end

endmodule

`default_nettype wire

// ==== design/mem_bus_if.sv ====
// Memory bus with req/gnt handshake and a registered rvalid response
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;

  logic               req;
  logic               gnt;
  logic               rvalid;
  logic               we;
  island_pkg::strb_t  be;
  island_pkg::addr_t  addr;
  island_pkg::data_t  wdata;
  island_pkg::data_t  rdata;
  logic               err;

  modport manager (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport subordinate (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

`default_nettype wire

// ==== design/periph_subsystem.sv ====
// Peripheral region with SoC control registers, boot ROM and error responder
`timescale 1ns/10ps
`default_nettype none

module periph_subsystem (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  mem_bus_if.subordinate         bus,
  input  island_pkg::boot_mode_e bootmode_i,
  output logic                   fetch_enable_o,
  output island_pkg::addr_t      boot_addr_o
);

  localparam int unsigned RomIdxW = $clog2(island_pkg::BootRomWords);

  island_pkg::addr_t offset;
  logic              in_region, regs_sel, rom_sel;
  logic              local_rvalid_q, local_err_q;
  island_pkg::data_t local_rdata_q;

  mem_bus_if reg_bus ();

  // --------------------
  // Decode
  // --------------------
  assign offset    = bus.addr - island_pkg::PeriphOffset;
  assign in_region = offset < (island_pkg::IslandEnd - island_pkg::PeriphOffset);
  assign regs_sel  = in_region
                     && (offset - island_pkg::SocCtrlOffset) < island_pkg::SocCtrlRange;
  assign rom_sel   = in_region
                     && (offset - island_pkg::BootRomOffset) < island_pkg::BootRomRange;

  assign reg_bus.req   = bus.req && regs_sel;
  assign reg_bus.we    = bus.we;
  assign reg_bus.be    = bus.be;
  assign reg_bus.addr  = offset - island_pkg::SocCtrlOffset;
  assign reg_bus.wdata = bus.wdata;

  assign bus.gnt = regs_sel ? reg_bus.gnt : bus.req;

  soc_ctrl_regs u_soc_ctrl (
    .clk_i,
    .rst_ni,
    .bus            ( reg_bus        ),
    .bootmode_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  // --------------------
  // Boot ROM and errors
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      local_rvalid_q <= 1'b0;
    end else begin
      local_rvalid_q <= bus.req && !regs_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !regs_sel) begin
      if (rom_sel && !bus.we) begin
        local_rdata_q <= island_pkg::boot_rom_table[bus.addr[RomIdxW+1:2]];
        local_err_q   <= 1'b0;
      end else begin
        // ROM writes fail like unmapped space
        local_rdata_q <= island_pkg::ErrorPattern;
        local_err_q   <= 1'b1;
      end
    end
  end

  assign bus.rvalid = reg_bus.rvalid | local_rvalid_q;
  assign bus.rdata  = reg_bus.rvalid ? reg_bus.rdata : local_rdata_q;
  assign bus.err    = reg_bus.rvalid ? reg_bus.err : local_err_q;

endmodule

`default_nettype wire

// ==== design/soc_ctrl_regs.sv ====
// SoC control registers for boot address, fetch enable and captured boot mode
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  mem_bus_if.subordinate         bus,
  input  island_pkg::boot_mode_e bootmode_i,
  output logic                   fetch_enable_o,
  output island_pkg::addr_t      boot_addr_o
);

  logic                   first_cycle_q;
  logic                   fetch_en_q;
  island_pkg::addr_t      boot_addr_q;
  island_pkg::boot_mode_e boot_mode_q;
  logic                   rvalid_q, err_q;
  island_pkg::data_t      rdata_q;
  logic                   wr;

  assign bus.gnt = bus.req;
  assign wr      = bus.req && bus.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
      fetch_en_q    <= 1'b0;
      boot_addr_q   <= island_pkg::BootAddrDefault;
      boot_mode_q   <= island_pkg::BootJtag;
      rvalid_q      <= 1'b0;
    end else begin
      first_cycle_q <= 1'b0;
      rvalid_q      <= bus.req;
      // Straps are sampled once, JTAG boot starts the core right away
      if (first_cycle_q) begin
        boot_mode_q <= bootmode_i;
        fetch_en_q  <= (bootmode_i == island_pkg::BootJtag);
      end
      if (wr && bus.addr == island_pkg::RegBootAddr) begin
        for (int b = 0; b < island_pkg::StrbWidth; b++) begin
          if (bus.be[b]) begin
            boot_addr_q[8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
      if (wr && bus.addr == island_pkg::RegFetchEn && bus.be[0]) begin
        fetch_en_q <= bus.wdata[0];
      end
    end
  end

  // Read data, boot mode is read-only
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      err_q <= 1'b0;
      case (bus.addr)
        island_pkg::RegBootAddr: rdata_q <= boot_addr_q;
        island_pkg::RegFetchEn:  rdata_q <= island_pkg::data_t'(fetch_en_q);
        island_pkg::RegBootMode: rdata_q <= island_pkg::data_t'(boot_mode_q);
        default: begin
          rdata_q <= '0;
          err_q   <= 1'b1;
        end
      endcase
    end
  end

  assign bus.rvalid     = rvalid_q;
  assign bus.rdata      = rdata_q;
  assign bus.err        = err_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

// ==== design/sram_bank.sv ====
// Single-port SRAM bank with byte enables and one-cycle read latency
`timescale 1ns/10ps
`default_nettype none

module sram_bank #(
  parameter int unsigned NumWords = 256
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  mem_bus_if.subordinate bus
);

  localparam int unsigned IdxW = $clog2(NumWords);

  typedef logic [IdxW-1:0] word_idx_t;

  island_pkg::data_t mem_q [NumWords];
  island_pkg::data_t rdata_q;
  logic              rvalid_q;
  word_idx_t         idx;

  assign idx     = bus.addr[IdxW+1:2];
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < island_pkg::StrbWidth; b++) begin
          if (bus.be[b]) begin
            mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

`default_nettype wire

// ==== sim/tb_island.sv ====
// Table-driven testbench for the island fabric with bank contention and peripheral checks
`timescale 1ns/10ps
`default_nettype none

module tb_island;

  localparam logic [1:0] OnM0   = 2'd0;
  localparam logic [1:0] OnM1   = 2'd1;
  localparam logic [1:0] PairM0 = 2'd2;
  localparam logic [1:0] PairM1 = 2'd3;

  localparam logic [1:0] WinM0   = 2'd0;
  localparam logic [1:0] WinM1   = 2'd1;
  localparam logic [1:0] WinBoth = 2'd2;

  localparam island_pkg::addr_t RegBase = island_pkg::PeriphOffset + island_pkg::SocCtrlOffset;
  localparam island_pkg::addr_t RomBase = island_pkg::PeriphOffset + island_pkg::BootRomOffset;
  localparam island_pkg::addr_t NewBootAddr = 32'h0000_0100;

  // Pair entries come in order with the m0 half first
  typedef struct packed {
    logic [1:0]        mode;
    logic              we;
    island_pkg::strb_t be;
    island_pkg::addr_t addr;
    island_pkg::data_t wdata;
    island_pkg::data_t exp_rdata;
    logic              exp_err;
    logic [1:0]        win;
  } step_t;

  logic clk_i;
  logic rst_ni;
  logic m0_req_i, m0_we_i, m1_req_i, m1_we_i;
  island_pkg::strb_t m0_be_i, m1_be_i;
  island_pkg::addr_t m0_addr_i, m1_addr_i;
  island_pkg::data_t m0_wdata_i, m1_wdata_i;
  logic m0_gnt_o, m0_rvalid_o, m0_err_o, m1_gnt_o, m1_rvalid_o, m1_err_o;
  island_pkg::data_t m0_rdata_o, m1_rdata_o;
  island_pkg::boot_mode_e bootmode_i;
  logic fetch_enable_o;
  island_pkg::addr_t boot_addr_o;

  step_t  steps[$];
  integer seed = 32'h9aa8;
  int     n_checks = 0;
  int     n_errors = 0;
  int     cycles = 0;
  int     cycle_limit = 0;

  island_top u_dut (
    .clk_i, .rst_ni,
    .m0_req_i, .m0_we_i, .m0_be_i, .m0_addr_i, .m0_wdata_i,
    .m0_gnt_o, .m0_rvalid_o, .m0_err_o, .m0_rdata_o,
    .m1_req_i, .m1_we_i, .m1_be_i, .m1_addr_i, .m1_wdata_i,
    .m1_gnt_o, .m1_rvalid_o, .m1_err_o, .m1_rdata_o,
    .bootmode_i, .fetch_enable_o, .boot_addr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a response never arrived", cycles);
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      $display("TEST FAIL");
      $finish;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic add_step(input logic [1:0] mode, input logic we, input island_pkg::strb_t be,
                          input island_pkg::addr_t addr, input island_pkg::data_t wdata,
                          input island_pkg::data_t exp_rdata, input logic exp_err,
                          input logic [1:0] win);
    step_t s;
    s = '{mode: mode, we: we, be: be, addr: addr, wdata: wdata,
          exp_rdata: exp_rdata, exp_err: exp_err, win: win};
    steps.push_back(s);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input island_pkg::data_t got,
                            input island_pkg::data_t exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic get_gnt(input int port);
    return (port != 0) ? m1_gnt_o : m0_gnt_o;
  endfunction

  task automatic drive_port(input int port, input step_t s);
    if (port == 0) begin
      m0_req_i   = 1'b1;
      m0_we_i    = s.we;
      m0_be_i    = s.be;
      m0_addr_i  = s.addr;
      m0_wdata_i = s.wdata;
    end else begin
      m1_req_i   = 1'b1;
      m1_we_i    = s.we;
      m1_be_i    = s.be;
      m1_addr_i  = s.addr;
      m1_wdata_i = s.wdata;
    end
  endtask

  task automatic idle_port(input int port);
    if (port == 0) begin
      m0_req_i   = 1'b0;
      m0_we_i    = 1'b0;
      m0_be_i    = '0;
      m0_addr_i  = '0;
      m0_wdata_i = '0;
    end else begin
      m1_req_i   = 1'b0;
      m1_we_i    = 1'b0;
      m1_be_i    = '0;
      m1_addr_i  = '0;
      m1_wdata_i = '0;
    end
  endtask

  task automatic check_rsp(input int port, input step_t s);
    check_bit($sformatf("m%0d_rvalid_o", port), (port != 0) ? m1_rvalid_o : m0_rvalid_o, 1'b1);
    if (!s.we) begin
      check_word($sformatf("m%0d_rdata_o", port), (port != 0) ? m1_rdata_o : m0_rdata_o,
                 s.exp_rdata);
    end
    check_bit($sformatf("m%0d_err_o", port), (port != 0) ? m1_err_o : m0_err_o, s.exp_err);
  endtask

  task automatic run_single(input step_t s);
    int port;
    port = (s.mode == OnM1) ? 1 : 0;
    @(posedge clk_i);
    #2;
    drive_port(port, s);
    #18;
    check_bit($sformatf("m%0d_gnt_o", port), get_gnt(port), 1'b1);
    while (get_gnt(port) !== 1'b1) begin
      @(posedge clk_i);
      #20;
    end
    @(posedge clk_i);
    #2;
    idle_port(port);
    #18;
    check_rsp(port, s);
  endtask

  task automatic run_pair(input step_t a, input step_t b);
    int    winner;
    step_t ws;
    step_t ls;
    @(posedge clk_i);
    #2;
    drive_port(0, a);
    drive_port(1, b);
    #18;
    if (a.win == WinBoth) begin
      check_bit("m0_gnt_o", m0_gnt_o, 1'b1);
      check_bit("m1_gnt_o", m1_gnt_o, 1'b1);
      @(posedge clk_i);
      #2;
      idle_port(0);
      idle_port(1);
      #18;
      check_rsp(0, a);
      check_rsp(1, b);
    end else begin
      winner = (a.win == WinM1) ? 1 : 0;
      ws = (winner != 0) ? b : a;
      ls = (winner != 0) ? a : b;
      check_bit($sformatf("m%0d_gnt_o", winner), get_gnt(winner), 1'b1);
      check_bit($sformatf("m%0d_gnt_o", 1 - winner), get_gnt(1 - winner), 1'b0);
      @(posedge clk_i);
      #2;
      idle_port(winner);
      #18;
      check_rsp(winner, ws);
      // Loser is served right behind the winner
      check_bit($sformatf("m%0d_gnt_o", 1 - winner), get_gnt(1 - winner), 1'b1);
      @(posedge clk_i);
      #2;
      idle_port(1 - winner);
      #18;
      check_rsp(1 - winner, ls);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    island_pkg::data_t w0, v0, w1, v1, w2, w3, merged0, merged1;
    int i;

    rst_ni = 1'b0;
    bootmode_i = island_pkg::BootJtag;
    idle_port(0);
    idle_port(1);

    w0 = $random(seed);
    v0 = $random(seed);
    w1 = $random(seed);
    v1 = $random(seed);
    w2 = $random(seed);
    w3 = $random(seed);
    // Byte lanes 0 and 2 from the second write and the rest kept
    merged0 = (v0 & 32'h00ff00ff) | (w0 & 32'hff00ff00);
    // Upper half from the second write
    merged1 = (v1 & 32'hffff0000) | (w1 & 32'h0000ffff);

    // Bank writes and merged read-back
    add_step(OnM0, 1'b1, 4'hf, 32'h010, w0, '0, 1'b0, WinBoth);
    add_step(OnM0, 1'b1, 4'h5, 32'h010, v0, '0, 1'b0, WinBoth);
    add_step(OnM1, 1'b1, 4'hf, 32'h420, w1, '0, 1'b0, WinBoth);
    add_step(OnM1, 1'b1, 4'hc, 32'h420, v1, '0, 1'b0, WinBoth);
    add_step(OnM0, 1'b0, 4'hf, 32'h420, '0, merged1, 1'b0, WinBoth);
    add_step(OnM1, 1'b0, 4'hf, 32'h010, '0, merged0, 1'b0, WinBoth);
    // SoC control registers
    add_step(OnM0, 1'b0, 4'hf, RegBase + island_pkg::RegBootMode, '0,
             32'(island_pkg::BootJtag), 1'b0, WinBoth);
    add_step(OnM1, 1'b1, 4'hf, RegBase + island_pkg::RegBootAddr, NewBootAddr, '0, 1'b0, WinBoth);
    add_step(OnM0, 1'b0, 4'hf, RegBase + island_pkg::RegBootAddr, '0, NewBootAddr, 1'b0, WinBoth);
    add_step(OnM0, 1'b1, 4'hf, RegBase + island_pkg::RegFetchEn, '0, '0, 1'b0, WinBoth);
    add_step(OnM1, 1'b0, 4'hf, RegBase + island_pkg::RegFetchEn, '0, '0, 1'b0, WinBoth);
    // Boot ROM
    add_step(OnM0, 1'b0, 4'hf, RomBase, '0, island_pkg::boot_rom_table[0], 1'b0, WinBoth);
    add_step(OnM1, 1'b0, 4'hf, RomBase + 32'h14, '0, island_pkg::boot_rom_table[5], 1'b0, WinBoth);
    add_step(OnM0, 1'b0, 4'hf, RomBase + 32'h3c, '0, island_pkg::boot_rom_table[15], 1'b0,
             WinBoth);
    add_step(OnM1, 1'b1, 4'hf, RomBase + 32'h8, w3, '0, 1'b1, WinBoth);
    // Unmapped space
    add_step(OnM0, 1'b0, 4'hf, island_pkg::PeriphOffset + 32'h2000, '0,
             island_pkg::ErrorPattern, 1'b1, WinBoth);
    add_step(OnM1, 1'b0, 4'hf, island_pkg::IslandEnd, '0, island_pkg::ErrorPattern, 1'b1, WinBoth);
    add_step(OnM0, 1'b0, 4'hf, 32'hffff_fff0, '0, island_pkg::ErrorPattern, 1'b1, WinBoth);
    // Conflicts on bank0 alternate
    add_step(OnM1, 1'b1, 4'hf, 32'h020, w2, '0, 1'b0, WinBoth);
    add_step(PairM0, 1'b0, 4'hf, 32'h010, '0, merged0, 1'b0, WinM0);
    add_step(PairM1, 1'b0, 4'hf, 32'h020, '0, w2, 1'b0, WinM0);
    add_step(PairM0, 1'b0, 4'hf, 32'h020, '0, w2, 1'b0, WinM1);
    add_step(PairM1, 1'b0, 4'hf, 32'h010, '0, merged0, 1'b0, WinM1);
    // Different banks in parallel
    add_step(OnM0, 1'b1, 4'hf, 32'h424, w3, '0, 1'b0, WinBoth);
    add_step(PairM0, 1'b0, 4'hf, 32'h020, '0, w2, 1'b0, WinBoth);
    add_step(PairM1, 1'b0, 4'hf, 32'h424, '0, w3, 1'b0, WinBoth);
    add_step(PairM0, 1'b0, 4'hf, 32'h420, '0, merged1, 1'b0, WinBoth);
    add_step(PairM1, 1'b0, 4'hf, 32'h010, '0, merged0, 1'b0, WinBoth);

    cycle_limit = 20 * steps.size() + 200;

    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);
    #20;
    check_bit("fetch_enable_o", fetch_enable_o, 1'b1);
    check_word("boot_addr_o", boot_addr_o, island_pkg::BootAddrDefault);

    i = 0;
    while (i < steps.size()) begin
      if (steps[i].mode == PairM0) begin
        run_pair(steps[i], steps[i + 1]);
        i += 2;
      end else begin
        run_single(steps[i]);
        i++;
      end
    end

    check_bit("fetch_enable_o", fetch_enable_o, 1'b0);
    check_word("boot_addr_o", boot_addr_o, NewBootAddr);

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
